// ==== logic/flow_params.svh ====
`ifndef FLOW_PARAMS_SVH
`define FLOW_PARAMS_SVH

// ---------------------------------------------------------------------------
// Stream aggregator sizing
// ---------------------------------------------------------------------------

// Number of input flows
`define FLOW_NUM_FLOWS 4

// Payload width in bits
`define FLOW_DATA_WIDTH 16

// Entries in each input FIFO
`define FLOW_IN_DEPTH 4

// Entries in the output FIFO
`define FLOW_OUT_DEPTH 2

// Most beats a single grant may move
`define FLOW_BURST_QUANTUM 4

`endif

// ==== logic/flow_pkg.sv ====
`include "flow_params.svh"

package flow_pkg;

  // ---------------------------------------------------------------------------
  // Payload and tag types
  // ---------------------------------------------------------------------------

  // One payload word of an input flow
  typedef logic [`FLOW_DATA_WIDTH-1:0] flow_beat_t;

  // Index of an input flow
  typedef logic [$clog2(`FLOW_NUM_FLOWS)-1:0] flow_src_t;

  // Beat after the mux, tagged with the flow it came from
  // Source sits in the upper bits
  typedef struct packed {
    flow_src_t  src;
    flow_beat_t data;
  } flow_tagged_t;

  // Beat count within one grant
  // Wide enough to hold the full quantum when saturated
  typedef logic [$clog2(`FLOW_BURST_QUANTUM + 1)-1:0] flow_beat_cnt_t;

endpackage

// ==== logic/flow_if.sv ====
`timescale 1ns/1ps

// Ready-valid link for tagged beats between the mux and the output FIFO
interface flow_if import flow_pkg::*; ();

  // Beat is offered when high
  logic         valid;

  // Receiver can take the beat when high
  logic         ready;

  // Payload plus source tag
  flow_tagged_t beat;

  // Mux side
  // Valid and beat must hold until the beat moves
  modport source (
    output valid,
    output beat,
    input  ready
  );

  // Output FIFO side
  modport sink (
    input  valid,
    input  beat,
    output ready
  );

endinterface

// ==== logic/flow_fifo.sv ====
`timescale 1ns/1ps

module flow_fifo import flow_pkg::*; #(
  parameter type payload_t = flow_beat_t,
  parameter int  DEPTH     = 2
) (
  input  logic     clk,
  input  logic     reset,

  input  logic     push_valid,
  output logic     push_ready,
  input  payload_t push_data,

  output logic     pop_valid,
  input  logic     pop_ready,
  output payload_t pop_data
);

  localparam int ptr_width   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int count_width = $clog2(DEPTH + 1);

  localparam logic [ptr_width-1:0]   last_ptr   = ptr_width'(DEPTH - 1);
  localparam logic [count_width-1:0] full_count = count_width'(DEPTH);

  // Storage, written only on an accepted push
  payload_t mem [DEPTH];

  logic [ptr_width-1:0]   wr_ptr;
  logic [ptr_width-1:0]   rd_ptr;
  logic [count_width-1:0] count;

  logic push_fire;
  logic pop_fire;

  // ---------------------------------------------------------------------------
  // Handshake
  // ---------------------------------------------------------------------------

  // Full blocks a push even if a pop happens in the same cycle
  assign push_ready = (count != full_count);
  assign pop_valid  = (count != '0);

  assign push_fire = push_valid & push_ready;
  assign pop_fire  = pop_valid & pop_ready;

  // Head entry comes straight from storage
  // A beat pushed this cycle is visible only after the edge
  assign pop_data = mem[rd_ptr];

  // ---------------------------------------------------------------------------
  // Storage and pointers
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (push_fire) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap at DEPTH, which need not be a power of two
      if (push_fire) begin
        wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_fire) begin
        rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave the count alone
      if (push_fire && !pop_fire) begin
        count <= count + 1'b1;
      end else if (pop_fire && !push_fire) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== logic/flow_mux_select.sv ====
`timescale 1ns/1ps

`include "flow_params.svh"

module flow_mux_select import flow_pkg::*; (
  // Flow chosen by the grant FSM
  input  flow_src_t                         select,

  // Pop sides of the input FIFOs
  input  logic [`FLOW_NUM_FLOWS-1:0]        req_valid,
  output logic [`FLOW_NUM_FLOWS-1:0]        req_ready,
  input  flow_beat_t [`FLOW_NUM_FLOWS-1:0]  req_data,

  // Low outside a grant
  input  logic                              grant_valid,

  // Tagged beat toward the output FIFO
  flow_if.source                            out
);

  // ---------------------------------------------------------------------------
  // Steering, zero cycles
  // ---------------------------------------------------------------------------

  always_comb begin
    // Defaults: nothing offered, nothing accepted
    req_ready     = '0;
    out.valid     = 1'b0;

    // Data and tag follow select even without a grant
    // Harmless, since valid is low then
    out.beat.src  = select;
    out.beat.data = req_data[select];

    if (grant_valid) begin
      out.valid         = req_valid[select];
      // Ready only reaches the selected flow
      req_ready[select] = out.ready;
    end
  end

endmodule

// ==== logic/beat_timer.sv ====
`timescale 1ns/1ps

`include "flow_params.svh"

module beat_timer import flow_pkg::*; (
  input  logic clk,
  input  logic reset,
  // Start of a new grant
  input  logic clear,
  // One transfer on the mux output
  input  logic beat,
  output logic quantum_reached
);

  localparam flow_beat_cnt_t quantum      = flow_beat_cnt_t'(`FLOW_BURST_QUANTUM);
  localparam flow_beat_cnt_t quantum_last = flow_beat_cnt_t'(`FLOW_BURST_QUANTUM - 1);

  // Transfers since the last clear
  flow_beat_cnt_t count;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (clear) begin
      count <= '0;
    end else if (beat && (count != quantum)) begin
      // Saturates at the quantum
      count <= count + 1'b1;
    end
  end

  // High during the last allowed beat
  // The transfer that sees this flag is the one that ends the grant
  assign quantum_reached = (count == quantum_last);

endmodule

// ==== logic/grant_fsm.sv ====
`timescale 1ns/1ps

`include "flow_params.svh"

module grant_fsm import flow_pkg::*; (
  input  logic                       clk,
  input  logic                       reset,

  // Non-empty flags of the input FIFOs
  input  logic [`FLOW_NUM_FLOWS-1:0] req_valid,

  // Beat moved on the mux output
  input  logic                       xfer,
  input  logic                       quantum_reached,

  output flow_src_t                  select,
  output logic                       grant_valid,
  output logic                       timer_clear
);

  typedef enum logic {
    state_idle,
    state_serve
  } state_t;

  state_t    state;

  // Round-robin pick, starting after the flow last served
  flow_src_t next_select;
  logic      found;

  // ---------------------------------------------------------------------------
  // Round-robin search
  // ---------------------------------------------------------------------------

  always_comb begin
    int idx;
    next_select = select;
    found       = 1'b0;
    // The last served flow is checked last
    for (int i = 1; i <= `FLOW_NUM_FLOWS; i++) begin
      idx = (int'(select) + i) % `FLOW_NUM_FLOWS;
      if (!found && req_valid[idx]) begin
        found       = 1'b1;
        next_select = flow_src_t'(idx);
      end
    end
  end

  // ---------------------------------------------------------------------------
  // State register
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= state_idle;
      select <= '0;
    end else begin
      case (state)
        state_idle: begin
          if (found) begin
            select <= next_select;
            state  <= state_serve;
          end
        end
        state_serve: begin
          // Select only moves from idle, so a waiting beat keeps its flow
          if (xfer && quantum_reached) begin
            state <= state_idle;
          end else if (!req_valid[select] && !xfer) begin
            // Granted FIFO ran dry
            state <= state_idle;
          end
        end
        default: state <= state_idle;
      endcase
    end
  end

  assign grant_valid = (state == state_serve);

  // Restart the beat count on the edge that opens a grant
  assign timer_clear = (state == state_idle) && found;

endmodule

// ==== logic/flow_aggregator.sv ====
`timescale 1ns/1ps

`include "flow_params.svh"

module flow_aggregator import flow_pkg::*; (
  input  logic                              clk,
  input  logic                              reset,

  // Input flows
  input  logic [`FLOW_NUM_FLOWS-1:0]        push_valid,
  output logic [`FLOW_NUM_FLOWS-1:0]        push_ready,
  input  flow_beat_t [`FLOW_NUM_FLOWS-1:0]  push_data,

  // Aggregated output
  output logic                              pop_valid,
  input  logic                              pop_ready,
  output flow_beat_t                        pop_data,
  output flow_src_t                         pop_src
);

  logic [`FLOW_NUM_FLOWS-1:0]       req_valid;
  logic [`FLOW_NUM_FLOWS-1:0]       req_ready;
  flow_beat_t [`FLOW_NUM_FLOWS-1:0] req_data;

  flow_src_t    select;
  logic         grant_valid;
  logic         timer_clear;
  logic         quantum_reached;
  logic         xfer;
  flow_tagged_t out_beat;

  flow_if tagged_if ();

  // ---------------------------------------------------------------------------
  // Input FIFOs, one per flow
  // ---------------------------------------------------------------------------

  for (genvar i = 0; i < `FLOW_NUM_FLOWS; i++) begin : g_in
    flow_fifo #(
      .payload_t (flow_beat_t),
      .DEPTH     (`FLOW_IN_DEPTH)
    ) u_in_fifo (
      .clk        (clk),
      .reset      (reset),
      .push_valid (push_valid[i]),
      .push_ready (push_ready[i]),
      .push_data  (push_data[i]),
      .pop_valid  (req_valid[i]),
      .pop_ready  (req_ready[i]),
      .pop_data   (req_data[i])
    );
  end

  // ---------------------------------------------------------------------------
  // Arbitration and steering
  // ---------------------------------------------------------------------------

  flow_mux_select u_mux (
    .select      (select),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .req_data    (req_data),
    .grant_valid (grant_valid),
    .out         (tagged_if.source)
  );

  // Beat moves from the mux into the output FIFO
  assign xfer = tagged_if.valid & tagged_if.ready;

  beat_timer u_timer (
    .clk             (clk),
    .reset           (reset),
    .clear           (timer_clear),
    .beat            (xfer),
    .quantum_reached (quantum_reached)
  );

  grant_fsm u_grant (
    .clk             (clk),
    .reset           (reset),
    .req_valid       (req_valid),
    .xfer            (xfer),
    .quantum_reached (quantum_reached),
    .select          (select),
    .grant_valid     (grant_valid),
    .timer_clear     (timer_clear)
  );

  // Output FIFO takes tagged beats
  flow_fifo #(
    .payload_t (flow_tagged_t),
    .DEPTH     (`FLOW_OUT_DEPTH)
  ) u_out_fifo (
    .clk        (clk),
    .reset      (reset),
    .push_valid (tagged_if.valid),
    .push_ready (tagged_if.ready),
    .push_data  (tagged_if.beat),
    .pop_valid  (pop_valid),
    .pop_ready  (pop_ready),
    .pop_data   (out_beat)
  );

  assign pop_data = out_beat.data;
  assign pop_src  = out_beat.src;

endmodule

// ==== verification/flow_aggregator_chk.sv ====
`timescale 1ns/1ps

`include "flow_params.svh"

module flow_aggregator_chk import flow_pkg::*; (
  input logic                       clk,
  input logic                       reset,
  input logic [`FLOW_NUM_FLOWS-1:0] push_ready,
  input logic                       pop_valid,
  input logic                       pop_ready,
  input flow_beat_t                 pop_data,
  input flow_src_t                  pop_src,
  input logic [`FLOW_NUM_FLOWS-1:0] req_valid,
  input flow_src_t                  select,
  input logic                       grant_valid,
  input logic                       xfer,
  input logic                       quantum_reached
);

  // Set by any failing property, watched from the testbench top
  logic failed = 1'b0;

  // First cycle out of reset, all FIFOs empty
  reset_empty: assert property (@(posedge clk)
    $fell(reset) |-> !pop_valid && (push_ready == '1))
    else begin
      failed = 1'b1;
      $error("Error pop_valid 0x%h push_ready 0x%h after reset", pop_valid, push_ready);
    end

  // ---------------------------------------------------------------------------
  // Output handshake
  // ---------------------------------------------------------------------------

  // A stalled beat keeps its value and tag
  stall_hold: assert property (@(posedge clk) disable iff (reset)
    pop_valid && !pop_ready |=> pop_valid && $stable(pop_data) && $stable(pop_src))
    else begin
      failed = 1'b1;
      $error("Error pop_data 0x%h -> 0x%h pop_src 0x%h -> 0x%h in stall",
             $past(pop_data), pop_data, $past(pop_src), pop_src);
    end

  // ---------------------------------------------------------------------------
  // Grant rules
  // ---------------------------------------------------------------------------

  // Mux beat waiting, so the grant and its select stay put
  select_hold: assert property (@(posedge clk) disable iff (reset)
    grant_valid && req_valid[select] && !xfer |=> grant_valid && $stable(select))
    else begin
      failed = 1'b1;
      $error("Error select 0x%h -> 0x%h with a beat waiting", $past(select), select);
    end

  // Last beat of the quantum closes the grant
  quantum_end: assert property (@(posedge clk) disable iff (reset)
    xfer && quantum_reached |=> !grant_valid)
    else begin
      failed = 1'b1;
      $error("Error grant_valid 0x%h after the last beat of a burst", grant_valid);
    end

endmodule

bind flow_aggregator flow_aggregator_chk u_chk (.*);

// ==== verification/flow_aggregator_tb.sv ====
`timescale 1ns/1ps

`include "flow_params.svh"

module flow_aggregator_tb import flow_pkg::*; ();

  localparam int n_flows       = `FLOW_NUM_FLOWS;
  localparam int random_cycles = 2000;
  // Worst case drain, every FIFO full, four cycles per entry
  localparam int drain_cycles  = n_flows * (`FLOW_IN_DEPTH + `FLOW_OUT_DEPTH) * 4;
  localparam int cycle_limit   = random_cycles + drain_cycles;
  // Output FIFO may still hold beats of the previous grant
  localparam int run_limit     = `FLOW_BURST_QUANTUM + `FLOW_OUT_DEPTH;

  logic                     clk = 1'b0;
  logic                     reset;
  logic [n_flows-1:0]       push_valid;
  logic [n_flows-1:0]       push_ready;
  flow_beat_t [n_flows-1:0] push_data;
  logic                     pop_valid;
  logic                     pop_ready;
  flow_beat_t               pop_data;
  flow_src_t                pop_src;

  // Accepted beats per source, oldest first
  flow_beat_t exp_q [n_flows][$];
  int         cycles  = 0;
  int         run_src = 0;
  int         run_len = 0;

  flow_aggregator UUT (
    .clk        (clk),
    .reset      (reset),
    .push_valid (push_valid),
    .push_ready (push_ready),
    .push_data  (push_data),
    .pop_valid  (pop_valid),
    .pop_ready  (pop_ready),
    .pop_data   (pop_data),
    .pop_src    (pop_src)
  );

  always #2 clk = ~clk;

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped at first failure");
  endtask

  function automatic bit other_pending(input int src);
    bit busy;
    busy = 1'b0;
    for (int i = 0; i < n_flows; i++) begin
      if (i != src && exp_q[i].size() != 0) begin
        busy = 1'b1;
      end
    end
    return busy;
  endfunction

  // Nothing offered, nothing queued, nothing at the output
  function automatic bit all_drained();
    return (push_valid == '0) && !pop_valid && !other_pending(-1);
  endfunction

  // Waiting beats stay on the bus; others get fresh random values
  task automatic drive_inputs(input logic [n_flows-1:0] hold, input bit new_beats);
    for (int i = 0; i < n_flows; i++) begin
      if (!hold[i]) begin
        push_valid[i] = new_beats && ($urandom_range(0, 1) == 1);
        push_data[i]  = flow_beat_t'($urandom());
      end
    end
    pop_ready = new_beats ? ($urandom_range(0, 3) != 0) : 1'b1;
  endtask

  // ---------------------------------------------------------------------------
  // Scoreboard, pushes first so a pop sees beats accepted on the same edge
  // ---------------------------------------------------------------------------

  always @(posedge clk) begin
    int src;
    if (!reset) begin
      for (int i = 0; i < n_flows; i++) begin
        if (push_valid[i] && push_ready[i]) begin
          exp_q[i].push_back(push_data[i]);
        end
      end
      if (pop_valid && pop_ready) begin
        src = int'(pop_src);
        have_beat: assert (exp_q[src].size() > 0)
          else fail_stop($sformatf("beat popped from source %0d with none sent", src));
        in_order: assert (pop_data == exp_q[src][0])
          else fail_stop($sformatf("Error pop_data src 0x%h: got 0x%h, expected 0x%h",
                                   pop_src, pop_data, exp_q[src][0]));
        void'(exp_q[src].pop_front());
        // Run length only counts while another flow is waiting
        if (!other_pending(src)) begin
          run_len = 0;
        end else if (src == run_src) begin
          run_len++;
        end else begin
          run_src = src;
          run_len = 1;
        end
        burst_len: assert (run_len <= run_limit)
          else fail_stop($sformatf("Error run_len src 0x%h: 0x%h above limit 0x%h",
                                   pop_src, run_len, run_limit));
      end
    end
  end

  // Timeout and bound checker watch
  always @(posedge clk) begin
    if (!reset) begin
      cycles++;
    end
    if (cycles >= cycle_limit) begin
      fail_stop("timeout: beats not drained");
    end
    if (UUT.u_chk.failed) begin
      fail_stop("an assertion in flow_aggregator_chk failed");
    end
  end

  initial begin
    logic [n_flows-1:0] hold;
    void'($urandom(32'ha0bf21bd));
    reset      = 1'b1;
    push_valid = '0;
    push_data  = '0;
    pop_ready  = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;

    repeat (random_cycles) begin
      @(posedge clk);
      hold = push_valid & ~push_ready;
      #1;
      drive_inputs(hold, 1'b1);
    end

    // Drain with pop_ready high until every queue is empty
    do begin
      @(posedge clk);
      hold = push_valid & ~push_ready;
      #1;
      drive_inputs(hold, 1'b0);
    end while (!all_drained());
    repeat (2) @(posedge clk);
    #1;

    if (all_drained()) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      fail_stop($sformatf("Error pop_valid 0x%h with beats left after drain", pop_valid));
    end
  end

endmodule

// ==== verilog.f ====
+incdir+logic
logic/flow_pkg.sv
logic/flow_if.sv
logic/flow_fifo.sv
logic/flow_mux_select.sv
logic/beat_timer.sv
logic/grant_fsm.sv
logic/flow_aggregator.sv
verification/flow_aggregator_chk.sv
verification/flow_aggregator_tb.sv

// ==== Bender.yml ====
package:
  name: flow_aggregator

sources:
  - include_dirs:
      - logic
    files:
      - logic/flow_pkg.sv
      - logic/flow_if.sv
      - logic/flow_fifo.sv
      - logic/flow_mux_select.sv
      - logic/beat_timer.sv
      - logic/grant_fsm.sv
      - logic/flow_aggregator.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/flow_aggregator_chk.sv
      - verification/flow_aggregator_tb.sv
